//--- vlog.f
+incdir+tests
verilog/vic_ext_pkg.sv
verilog/ext_reg_decoder.sv
verilog/video_memories.sv
verilog/palette_lookup.sv
verilog/vic_ext_top.sv
tests/tb_vic_ext.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vic_ext
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_vic_ext_tasks.svh
`ifndef TB_VIC_EXT_TASKS_SVH
`define TB_VIC_EXT_TASKS_SVH

// all bus tasks start and end on a falling edge
task automatic bus_write(input vic_ext_pkg::reg_addr_t a, input vic_ext_pkg::data_t d);
        bus_req = 1'b1;
        rw      = 1'b0;
        addr    = a;
        dbi     = d;
        while (!bus_ready) @(negedge clk_dot4x);
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        bus_req = 1'b0;
endtask

task automatic bus_read(input vic_ext_pkg::reg_addr_t a, output vic_ext_pkg::data_t d);
        bus_req = 1'b1;
        rw      = 1'b1;
        addr    = a;
        while (!bus_ready) @(negedge clk_dot4x);
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        bus_req = 1'b0;
        while (!rd_valid) @(negedge clk_dot4x);
        d = dbo;
endtask

task automatic expect_value(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
                errors++;
                $display("FAILED at %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
endtask

task automatic expect_read(input vic_ext_pkg::reg_addr_t a, input vic_ext_pkg::data_t exp,
                           input string what);
        vic_ext_pkg::data_t got;
        bus_read(a, got);
        expect_value(what, got, exp);
endtask

task automatic run_reset_checks();
        vic_ext_pkg::reg_addr_t regs [6];
        vic_ext_pkg::data_t     val;
        regs = '{6'h35, 6'h36, 6'h39, 6'h3a, 6'h3c, 6'h3d};
        expect_value("bus_ready after reset", {7'd0, bus_ready}, 8'd1);
        expect_value("rd_valid after reset", {7'd0, rd_valid}, 8'd0);
        expect_read(6'h00, 8'hff, "unmapped read");
        foreach (regs[i]) begin
                val = 8'($random(seed));
                bus_write(regs[i], val);
                expect_read(regs[i], val, "pointer register readback");
        end
endtask

task automatic run_unlock_checks();
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h21);
        expect_read(vic_ext_pkg::REG_MEM_FLAGS, 8'h00, "flags before unlock");
        // broken sequence
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h56);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h58);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h49);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h43);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h32);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h05);
        expect_read(vic_ext_pkg::REG_MEM_FLAGS, 8'h00, "flags after broken sequence");
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h56);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h49);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h43);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h32);
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h03);
        expect_read(vic_ext_pkg::REG_MEM_FLAGS, 8'h03, "flags after unlock");
endtask

task automatic run_vram_checks();
        vic_ext_pkg::data_t data [6];
        vic_ext_pkg::data_t idx;
        vic_ext_pkg::data_t idx2;
        logic [15:0]        start;
        logic [15:0]        last;
        logic [15:0]        ptr;
        idx   = 8'($random(seed)) | 8'h01;
        idx2  = idx ^ (8'($random(seed)) | 8'h01);
        start = {8'($random(seed)), 8'hfe};
        // pointer 1 increments, pointer 2 decrements
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h09);
        bus_write(vic_ext_pkg::REG_MEM_1_IDX, idx);
        bus_write(vic_ext_pkg::REG_MEM_1_HI, start[15:8]);
        bus_write(vic_ext_pkg::REG_MEM_1_LO, start[7:0]);
        foreach (data[k]) begin
                data[k] = 8'($random(seed));
                bus_write(vic_ext_pkg::REG_MEM_1_VAL, data[k]);
        end
        ptr = start + 16'd6;
        expect_read(vic_ext_pkg::REG_MEM_1_HI, ptr[15:8], "pointer 1 hi after writes");
        expect_read(vic_ext_pkg::REG_MEM_1_LO, ptr[7:0], "pointer 1 lo after writes");
        // pointer 2 reaches the last byte through its own index
        last = start + 16'd5 + {8'h00, idx} - {8'h00, idx2};
        bus_write(vic_ext_pkg::REG_MEM_2_IDX, idx2);
        bus_write(vic_ext_pkg::REG_MEM_2_HI, last[15:8]);
        bus_write(vic_ext_pkg::REG_MEM_2_LO, last[7:0]);
        for (int k = 5; k >= 0; k--) begin
                expect_read(vic_ext_pkg::REG_MEM_2_VAL, data[k], "video ram through pointer 2");
        end
        ptr = last - 16'd6;
        expect_read(vic_ext_pkg::REG_MEM_2_HI, ptr[15:8], "pointer 2 hi after reads");
        expect_read(vic_ext_pkg::REG_MEM_2_LO, ptr[7:0], "pointer 2 lo after reads");
endtask

task automatic read_nibbles(input logic [3:0] nib [4]);
        bus_write(vic_ext_pkg::REG_MEM_1_LO, 8'h0c);
        for (int n = 0; n < 4; n++) begin
                expect_read(vic_ext_pkg::REG_MEM_1_VAL, {4'h0, nib[n]}, "colour nibble");
        end
endtask

task automatic run_overlay_checks();
        logic [3:0]         nib [4];
        vic_ext_pkg::data_t vbyte;
        // overlay on, pointer 1 increments, entry 3 of palette 0
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h21);
        bus_write(vic_ext_pkg::REG_MEM_1_HI, 8'h00);
        bus_write(vic_ext_pkg::REG_MEM_1_LO, 8'h0c);
        for (int n = 0; n < 4; n++) begin
                nib[n] = 4'($random(seed));
                // upper bits of the byte must be ignored
                bus_write(vic_ext_pkg::REG_MEM_1_VAL, {4'($random(seed)), nib[n]});
        end
        read_nibbles(nib);
        nib[2] = ~nib[2];
        bus_write(vic_ext_pkg::REG_MEM_1_LO, 8'h0e);
        bus_write(vic_ext_pkg::REG_MEM_1_VAL, {4'h0, nib[2]});
        read_nibbles(nib);
        // overlay off, same pointer lands in video ram
        vbyte = 8'($random(seed)) | 8'h10;
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h01);
        bus_write(vic_ext_pkg::REG_MEM_1_LO, 8'h0c);
        bus_write(vic_ext_pkg::REG_MEM_1_VAL, vbyte);
        bus_write(vic_ext_pkg::REG_MEM_1_LO, 8'h0c);
        expect_read(vic_ext_pkg::REG_MEM_1_VAL, vbyte, "video ram byte without overlay");
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h21);
        read_nibbles(nib);
endtask

task automatic load_entry(input vic_ext_pkg::pal_addr_t e, input vic_ext_pkg::color_entry_t v);
        bus_write(vic_ext_pkg::REG_MEM_1_HI, 8'h00);
        bus_write(vic_ext_pkg::REG_MEM_1_LO, {1'b0, e, 2'b00});
        bus_write(vic_ext_pkg::REG_MEM_1_VAL, {4'h0, v[15:12]});
        bus_write(vic_ext_pkg::REG_MEM_1_VAL, {4'h0, v[11:8]});
        bus_write(vic_ext_pkg::REG_MEM_1_VAL, {4'h0, v[7:4]});
        bus_write(vic_ext_pkg::REG_MEM_1_VAL, {4'h0, v[3:0]});
endtask

task automatic check_pixel(input logic pal, input vic_ext_pkg::color_idx_t idx,
                           input vic_ext_pkg::color_entry_t v, input logic half,
                           input logic act);
        logic [3:0] exp_r;
        logic [3:0] exp_g;
        logic [3:0] exp_b;
        bus_write(vic_ext_pkg::REG_VIDEO_MODE, pal ? 8'h10 : 8'h00);
        expect_read(vic_ext_pkg::REG_VIDEO_MODE, pal ? 8'h10 : 8'h00, "video mode readback");
        pixel_color4 = idx;
        half_bright  = half;
        active       = act;
        @(posedge clk_dot4x);
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        exp_r = act ? (half ? v[15:12] >> 1 : v[15:12]) : 4'h0;
        exp_g = act ? (half ? v[11:8] >> 1 : v[11:8]) : 4'h0;
        exp_b = act ? (half ? v[7:4] >> 1 : v[7:4]) : 4'h0;
        expect_value("red", {4'h0, red}, {4'h0, exp_r});
        expect_value("green", {4'h0, green}, {4'h0, exp_g});
        expect_value("blue", {4'h0, blue}, {4'h0, exp_b});
endtask

task automatic run_pixel_checks();
        vic_ext_pkg::color_entry_t pal0_val;
        vic_ext_pkg::color_entry_t pal1_val;
        pal0_val = 16'($random(seed));
        pal1_val = 16'($random(seed));
        bus_write(vic_ext_pkg::REG_MEM_FLAGS, 8'h21);
        // same pixel index in both palettes
        load_entry(5'h07, pal0_val);
        load_entry(5'h17, pal1_val);
        check_pixel(1'b0, 4'h7, pal0_val, 1'b0, 1'b1);
        check_pixel(1'b1, 4'h7, pal1_val, 1'b0, 1'b1);
        check_pixel(1'b1, 4'h7, pal1_val, 1'b1, 1'b1);
        check_pixel(1'b0, 4'h7, pal0_val, 1'b1, 1'b1);
        check_pixel(1'b0, 4'h7, pal0_val, 1'b0, 1'b0);
        active = 1'b0;
endtask

`endif

//--- tests/tb_vic_ext.sv
`timescale 1ns/1ns

module tb_vic_ext;

        // rough count of bus operations over all tests
        localparam int NUM_OPS = 200;
        localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + 200;

        logic                    clk_dot4x;
        logic                    rst;
        logic                    bus_req;
        logic                    rw;
        vic_ext_pkg::reg_addr_t  addr;
        vic_ext_pkg::data_t      dbi;
        vic_ext_pkg::color_idx_t pixel_color4;
        logic                    half_bright;
        logic                    active;
        logic                    bus_ready;
        logic                    rd_valid;
        vic_ext_pkg::data_t      dbo;
        vic_ext_pkg::rgb_t       red;
        vic_ext_pkg::rgb_t       green;
        vic_ext_pkg::rgb_t       blue;

        int seed;
        int errors;
        int checks;

        vic_ext_top #(
                .VRAM_ADDR_W(15)
        ) u_vic_ext_top (
                .clk_dot4x    (clk_dot4x),
                .rst          (rst),
                .bus_req      (bus_req),
                .rw           (rw),
                .addr         (addr),
                .dbi          (dbi),
                .pixel_color4 (pixel_color4),
                .half_bright  (half_bright),
                .active       (active),
                .bus_ready    (bus_ready),
                .rd_valid     (rd_valid),
                .dbo          (dbo),
                .red          (red),
                .green        (green),
                .blue         (blue)
        );

        `include "tb_vic_ext_tasks.svh"

        always #4 clk_dot4x = ~clk_dot4x;

        // watchdog
        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk_dot4x);
                $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display("Simulation FAILED");
                $finish;
        end

        initial begin
                seed         = 27613;
                errors       = 0;
                checks       = 0;
                clk_dot4x    = 1'b0;
                rst          = 1'b1;
                bus_req      = 1'b0;
                rw           = 1'b1;
                addr         = '0;
                dbi          = '0;
                pixel_color4 = '0;
                half_bright  = 1'b0;
                active       = 1'b0;

                repeat (8) @(posedge clk_dot4x);
                @(negedge clk_dot4x);
                rst = 1'b0;

                run_reset_checks();
                run_unlock_checks();
                run_vram_checks();
                run_overlay_checks();
                run_pixel_checks();

                repeat (4) @(negedge clk_dot4x);
                $display("checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

endmodule

//--- verilog/vic_ext_top.sv
`timescale 1ns/1ns

module vic_ext_top #(
        parameter int VRAM_ADDR_W = 15
) (
        input  logic                    clk_dot4x,
        input  logic                    rst,
        input  logic                    bus_req,
        input  logic                    rw,
        input  vic_ext_pkg::reg_addr_t  addr,
        input  vic_ext_pkg::data_t      dbi,
        input  vic_ext_pkg::color_idx_t pixel_color4,
        input  logic                    half_bright,
        input  logic                    active,
        output logic                    bus_ready,
        output logic                    rd_valid,
        output vic_ext_pkg::data_t      dbo,
        output vic_ext_pkg::rgb_t       red,
        output vic_ext_pkg::rgb_t       green,
        output vic_ext_pkg::rgb_t       blue
);

        logic [VRAM_ADDR_W-1:0]    vram_addr;
        logic                      vram_we;
        vic_ext_pkg::data_t        vram_wdata;
        vic_ext_pkg::data_t        vram_rdata;
        vic_ext_pkg::pal_addr_t    color_addr;
        logic                      color_we;
        vic_ext_pkg::color_entry_t color_wdata;
        vic_ext_pkg::color_entry_t color_rdata;
        vic_ext_pkg::color_entry_t pix_entry;
        logic                      palette_select;

        // cpu side register decode
        ext_reg_decoder #(
                .VRAM_ADDR_W(VRAM_ADDR_W)
        ) u_ext_reg_decoder (
                .clk_dot4x      (clk_dot4x),
                .rst            (rst),
                .bus_req        (bus_req),
                .rw             (rw),
                .addr           (addr),
                .dbi            (dbi),
                .vram_rdata     (vram_rdata),
                .color_rdata    (color_rdata),
                .bus_ready      (bus_ready),
                .rd_valid       (rd_valid),
                .dbo            (dbo),
                .vram_addr      (vram_addr),
                .vram_we        (vram_we),
                .vram_wdata     (vram_wdata),
                .color_addr     (color_addr),
                .color_we       (color_we),
                .color_wdata    (color_wdata),
                .palette_select (palette_select)
        );

        video_memories #(
                .VRAM_ADDR_W(VRAM_ADDR_W)
        ) u_video_memories (
                .clk_dot4x      (clk_dot4x),
                .vram_addr      (vram_addr),
                .vram_we        (vram_we),
                .vram_wdata     (vram_wdata),
                .color_addr     (color_addr),
                .color_we       (color_we),
                .color_wdata    (color_wdata),
                .palette_select (palette_select),
                .pixel_color4   (pixel_color4),
                .vram_rdata     (vram_rdata),
                .color_rdata    (color_rdata),
                .pix_entry      (pix_entry)
        );

        // pixel output stage
        palette_lookup u_palette_lookup (
                .clk_dot4x   (clk_dot4x),
                .rst         (rst),
                .pix_entry   (pix_entry),
                .half_bright (half_bright),
                .active      (active),
                .red         (red),
                .green       (green),
                .blue        (blue)
        );

endmodule

//--- verilog/palette_lookup.sv
`timescale 1ns/1ns

module palette_lookup (
        input  logic                      clk_dot4x,
        input  logic                      rst,
        input  vic_ext_pkg::color_entry_t pix_entry,
        input  logic                      half_bright,
        input  logic                      active,
        output vic_ext_pkg::rgb_t         red,
        output vic_ext_pkg::rgb_t         green,
        output vic_ext_pkg::rgb_t         blue
);

        // controls lag one cycle to line up with the ram read
        logic half_bright_d;
        logic active_d;

        // half bright keeps the top three bits, shifted down
        function automatic vic_ext_pkg::rgb_t shade(input vic_ext_pkg::rgb_t c, input logic half);
                return half ? {1'b0, c[3:1]} : c;
        endfunction

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        half_bright_d <= 1'b0;
                        active_d      <= 1'b0;
                        red           <= '0;
                        green         <= '0;
                        blue          <= '0;
                end else begin
                        half_bright_d <= half_bright;
                        active_d      <= active;
                        if (active_d) begin
                                red   <= shade(pix_entry[15:12], half_bright_d);
                                green <= shade(pix_entry[11:8], half_bright_d);
                                blue  <= shade(pix_entry[7:4], half_bright_d);
                        end else begin
                                // blanked
                                red   <= '0;
                                green <= '0;
                                blue  <= '0;
                        end
                end
        end

endmodule

//--- verilog/video_memories.sv
`timescale 1ns/1ns

module video_memories #(
        parameter int VRAM_ADDR_W = 15
) (
        input  logic                      clk_dot4x,
        input  logic [VRAM_ADDR_W-1:0]    vram_addr,
        input  logic                      vram_we,
        input  vic_ext_pkg::data_t        vram_wdata,
        input  vic_ext_pkg::pal_addr_t    color_addr,
        input  logic                      color_we,
        input  vic_ext_pkg::color_entry_t color_wdata,
        input  logic                      palette_select,
        input  vic_ext_pkg::color_idx_t   pixel_color4,
        output vic_ext_pkg::data_t        vram_rdata,
        output vic_ext_pkg::color_entry_t color_rdata,
        output vic_ext_pkg::color_entry_t pix_entry
);

        localparam int COLOR_DEPTH = 2 ** $bits(vic_ext_pkg::pal_addr_t);

        vic_ext_pkg::data_t        vram [2 ** VRAM_ADDR_W];
        vic_ext_pkg::color_entry_t color_ram [COLOR_DEPTH];
        vic_ext_pkg::pal_addr_t    pix_addr;

        // pixel side picks the entry from the selected palette
        assign pix_addr = {palette_select, pixel_color4};

        // cpu port of the video ram, write first
        always_ff @(posedge clk_dot4x) begin
                if (vram_we) begin
                        vram[vram_addr] <= vram_wdata;
                        vram_rdata      <= vram_wdata;
                end else begin
                        vram_rdata <= vram[vram_addr];
                end
        end

        // colour registers port a, cpu read and write
        always_ff @(posedge clk_dot4x) begin
                if (color_we) begin
                        color_ram[color_addr] <= color_wdata;
                        color_rdata           <= color_wdata;
                end else begin
                        color_rdata <= color_ram[color_addr];
                end
        end

        // port b, read only
        always_ff @(posedge clk_dot4x) begin
                pix_entry <= color_ram[pix_addr];
        end

endmodule

//--- verilog/ext_reg_decoder.sv
`timescale 1ns/1ns

module ext_reg_decoder #(
        parameter int VRAM_ADDR_W = 15
) (
        input  logic                      clk_dot4x,
        input  logic                      rst,
        input  logic                      bus_req,
        input  logic                      rw,
        input  vic_ext_pkg::reg_addr_t    addr,
        input  vic_ext_pkg::data_t        dbi,
        input  vic_ext_pkg::data_t        vram_rdata,
        input  vic_ext_pkg::color_entry_t color_rdata,
        output logic                      bus_ready,
        output logic                      rd_valid,
        output vic_ext_pkg::data_t        dbo,
        output logic [VRAM_ADDR_W-1:0]    vram_addr,
        output logic                      vram_we,
        output vic_ext_pkg::data_t        vram_wdata,
        output vic_ext_pkg::pal_addr_t    color_addr,
        output logic                      color_we,
        output vic_ext_pkg::color_entry_t color_wdata,
        output logic                      palette_select
);

        // accepted request, acted on one edge later
        logic                       req_valid;
        logic                       req_rw;
        vic_ext_pkg::reg_addr_t     req_addr;
        vic_ext_pkg::data_t         req_dbi;

        vic_ext_pkg::access_state_t state;
        logic                       data_wait;
        logic [1:0]                 nib_sel;

        logic [1:0]                 unlock_cnt;
        logic                       unlocked;
        vic_ext_pkg::data_t         unlock_expect;
        vic_ext_pkg::data_t         flags;
        vic_ext_pkg::data_t         ptr_hi [2];
        vic_ext_pkg::data_t         ptr_lo [2];
        vic_ext_pkg::data_t         ptr_idx [2];

        logic                       port_hit;
        logic                       port_sel;
        logic [1:0]                 port_mode;
        logic                       overlay_hit;
        logic [15:0]                vram_full;
        logic                       hold_bus;
        vic_ext_pkg::data_t         reg_rdata;

        function automatic logic [15:0] step_ptr(input logic [15:0] ptr,
                                                 input logic [1:0] mode);
                case (mode)
                        vic_ext_pkg::STEP_INC: return ptr + 16'd1;
                        vic_ext_pkg::STEP_DEC: return ptr - 16'd1;
                        default: return ptr;
                endcase
        endfunction

        // nibble 0 is the top of the entry
        function automatic logic [3:0] pick_nibble(input vic_ext_pkg::color_entry_t e,
                                                   input logic [1:0] n);
                return e[(3 - n) * 4 +: 4];
        endfunction

        function automatic vic_ext_pkg::color_entry_t merge_nibble(
                        input vic_ext_pkg::color_entry_t e,
                        input logic [1:0] n,
                        input logic [3:0] v);
                vic_ext_pkg::color_entry_t r;
                r = e;
                r[(3 - n) * 4 +: 4] = v;
                return r;
        endfunction

        assign port_hit = (req_addr == vic_ext_pkg::REG_MEM_1_VAL) ||
                          (req_addr == vic_ext_pkg::REG_MEM_2_VAL);
        assign port_sel = (req_addr == vic_ext_pkg::REG_MEM_2_VAL);
        assign port_mode = flags[port_sel * 2 +: 2];
        // low half of the pointer space maps onto the colour registers
        assign overlay_hit = flags[vic_ext_pkg::FLAG_OVERLAY_BIT] && (ptr_lo[port_sel] < 8'h80);
        assign vram_full = {ptr_hi[port_sel], ptr_lo[port_sel]} + {8'h00, ptr_idx[port_sel]};

        // memory reads and colour writes hold the bus until they finish
        assign hold_bus = req_valid && port_hit && (req_rw || overlay_hit);
        assign bus_ready = (state == vic_ext_pkg::ST_IDLE) && !hold_bus;

        always_comb begin
                case (unlock_cnt)
                        2'd0: unlock_expect = vic_ext_pkg::UNLOCK_V;
                        2'd1: unlock_expect = vic_ext_pkg::UNLOCK_I;
                        2'd2: unlock_expect = vic_ext_pkg::UNLOCK_C;
                        default: unlock_expect = vic_ext_pkg::UNLOCK_2;
                endcase
        end

        always_comb begin
                case (req_addr)
                        vic_ext_pkg::REG_MEM_1_IDX: reg_rdata = ptr_idx[0];
                        vic_ext_pkg::REG_MEM_2_IDX: reg_rdata = ptr_idx[1];
                        vic_ext_pkg::REG_VIDEO_MODE:
                                reg_rdata = 8'(palette_select) << vic_ext_pkg::VMODE_PALETTE_BIT;
                        vic_ext_pkg::REG_MEM_1_HI: reg_rdata = ptr_hi[0];
                        vic_ext_pkg::REG_MEM_1_LO: reg_rdata = ptr_lo[0];
                        vic_ext_pkg::REG_MEM_2_HI: reg_rdata = ptr_hi[1];
                        vic_ext_pkg::REG_MEM_2_LO: reg_rdata = ptr_lo[1];
                        vic_ext_pkg::REG_MEM_FLAGS: reg_rdata = flags;
                        default: reg_rdata = vic_ext_pkg::UNMAPPED_READ;
                endcase
        end

        always_ff @(posedge clk_dot4x) begin
                if (bus_req && bus_ready) begin
                        req_rw   <= rw;
                        req_addr <= addr;
                        req_dbi  <= dbi;
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        req_valid      <= 1'b0;
                        state          <= vic_ext_pkg::ST_IDLE;
                        data_wait      <= 1'b0;
                        rd_valid       <= 1'b0;
                        vram_we        <= 1'b0;
                        color_we       <= 1'b0;
                        unlock_cnt     <= 2'd0;
                        unlocked       <= 1'b0;
                        flags          <= '0;
                        palette_select <= 1'b0;
                        for (int i = 0; i < 2; i++) begin
                                ptr_hi[i]  <= '0;
                                ptr_lo[i]  <= '0;
                                ptr_idx[i] <= '0;
                        end
                end else begin
                        req_valid <= bus_req && bus_ready;
                        rd_valid  <= 1'b0;
                        vram_we   <= 1'b0;
                        color_we  <= 1'b0;

                        if (req_valid && req_rw && !port_hit) begin
                                dbo      <= reg_rdata;
                                rd_valid <= 1'b1;
                        end

                        if (req_valid && !req_rw) begin
                                case (req_addr)
                                        vic_ext_pkg::REG_MEM_1_IDX: ptr_idx[0] <= req_dbi;
                                        vic_ext_pkg::REG_MEM_2_IDX: ptr_idx[1] <= req_dbi;
                                        vic_ext_pkg::REG_VIDEO_MODE:
                                                palette_select <= req_dbi[vic_ext_pkg::VMODE_PALETTE_BIT];
                                        vic_ext_pkg::REG_MEM_1_HI: ptr_hi[0] <= req_dbi;
                                        vic_ext_pkg::REG_MEM_1_LO: ptr_lo[0] <= req_dbi;
                                        vic_ext_pkg::REG_MEM_2_HI: ptr_hi[1] <= req_dbi;
                                        vic_ext_pkg::REG_MEM_2_LO: ptr_lo[1] <= req_dbi;
                                        vic_ext_pkg::REG_MEM_FLAGS: begin
                                                if (unlocked) begin
                                                        flags <= req_dbi;
                                                end else if (req_dbi == unlock_expect) begin
                                                        // last letter of the sequence
                                                        unlocked   <= (unlock_cnt == 2'd3);
                                                        unlock_cnt <= unlock_cnt + 2'd1;
                                                end else begin
                                                        unlock_cnt <= 2'd0;
                                                end
                                        end
                                        default: ;
                                endcase
                        end

                        // data port access, pointer steps as one 16-bit value
                        if (req_valid && port_hit) begin
                                {ptr_hi[port_sel], ptr_lo[port_sel]} <=
                                        step_ptr({ptr_hi[port_sel], ptr_lo[port_sel]}, port_mode);
                                nib_sel    <= ptr_lo[port_sel][1:0];
                                color_addr <= ptr_lo[port_sel][6:2];
                                vram_addr  <= vram_full[VRAM_ADDR_W-1:0];
                                vram_wdata <= req_dbi;
                                data_wait  <= 1'b0;
                                if (overlay_hit) begin
                                        state <= req_rw ? vic_ext_pkg::ST_COLOR_READ :
                                                          vic_ext_pkg::ST_COLOR_RMW;
                                end else if (req_rw) begin
                                        state <= vic_ext_pkg::ST_VRAM_READ;
                                end else begin
                                        vram_we <= 1'b1;
                                end
                        end

                        // one edge for the ram to answer, then finish
                        if (state != vic_ext_pkg::ST_IDLE) begin
                                data_wait <= 1'b1;
                                if (data_wait) begin
                                        state <= vic_ext_pkg::ST_IDLE;
                                        case (state)
                                                vic_ext_pkg::ST_VRAM_READ: begin
                                                        dbo      <= vram_rdata;
                                                        rd_valid <= 1'b1;
                                                end
                                                vic_ext_pkg::ST_COLOR_READ: begin
                                                        dbo      <= {4'h0, pick_nibble(color_rdata, nib_sel)};
                                                        rd_valid <= 1'b1;
                                                end
                                                default: begin
                                                        color_wdata <= merge_nibble(color_rdata, nib_sel,
                                                                                    req_dbi[3:0]);
                                                        color_we    <= 1'b1;
                                                end
                                        endcase
                                end
                        end
                end
        end

endmodule

//--- verilog/vic_ext_pkg.sv
package vic_ext_pkg;

        typedef logic [5:0] reg_addr_t;
        typedef logic [7:0] data_t;
        typedef logic [3:0] color_idx_t;
        // palette bit above the entry number
        typedef logic [4:0] pal_addr_t;
        // red 15..12, green 11..8, blue 7..4, low nibble spare
        typedef logic [15:0] color_entry_t;
        typedef logic [3:0] rgb_t;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_VRAM_READ,
                ST_COLOR_READ,
                ST_COLOR_RMW
        } access_state_t;

        // extension register map
        localparam reg_addr_t REG_MEM_1_IDX  = 6'h35;
        localparam reg_addr_t REG_MEM_2_IDX  = 6'h36;
        localparam reg_addr_t REG_VIDEO_MODE = 6'h37;
        localparam reg_addr_t REG_MEM_1_HI   = 6'h39;
        localparam reg_addr_t REG_MEM_1_LO   = 6'h3a;
        localparam reg_addr_t REG_MEM_1_VAL  = 6'h3b;
        localparam reg_addr_t REG_MEM_2_HI   = 6'h3c;
        localparam reg_addr_t REG_MEM_2_LO   = 6'h3d;
        localparam reg_addr_t REG_MEM_2_VAL  = 6'h3e;
        localparam reg_addr_t REG_MEM_FLAGS  = 6'h3f;

        // flags: step mode of pointer 1 in 1..0, pointer 2 in 3..2
        localparam int FLAG_OVERLAY_BIT  = 5;
        localparam int VMODE_PALETTE_BIT = 4;
        localparam logic [1:0] STEP_INC  = 2'd1;
        localparam logic [1:0] STEP_DEC  = 2'd2;

        // "VIC2" written to the flags register unlocks it
        localparam data_t UNLOCK_V = 8'h56;
        localparam data_t UNLOCK_I = 8'h49;
        localparam data_t UNLOCK_C = 8'h43;
        localparam data_t UNLOCK_2 = 8'h32;

        localparam data_t UNMAPPED_READ = 8'hff;

endpackage
